// File: rtl/vga_pkg.sv
package vga_pkg;

    // phases of one line or one frame, in scan order
    typedef enum logic [1:0] {
        ph_active = 2'd0,
        ph_front  = 2'd1,
        ph_pulse  = 2'd2,
        ph_back   = 2'd3
    } scan_phase_e;

    typedef enum logic [1:0] {
        mode_solid = 2'd0,
        mode_bars  = 2'd1,
        mode_grid  = 2'd2,
        mode_xor   = 2'd3
    } pattern_mode_e;

    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [1:0] blue;
    } pixel_t;          // RRRGGGBB

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       active;
        logic       hsync_n;
        logic       vsync_n;
        logic       frame_start;    // only at x 0, y 0
    } beam_t;

    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    localparam logic [3:0] reg_ctrl   = 4'h0;   // bit 0 enable, bits 2:1 mode
    localparam logic [3:0] reg_color  = 4'h4;   // bits 7:0 solid colour
    localparam logic [3:0] reg_frames = 4'h8;   // read only
    localparam logic [3:0] reg_status = 4'hc;   // read only, bit 0 vblank

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// File: rtl/vga_timing.sv
module vga_timing import vga_pkg::*; #(
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_pulse  = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_pulse  = 2,
    parameter int v_back   = 33
) (
    input  logic  clk,
    input  logic  rst,
    output beam_t beam,
    output logic  vblank
);

    scan_phase_e h_phase;
    scan_phase_e v_phase;
    logic [9:0]  h_cnt;     // clocks spent in the current h phase
    logic [9:0]  v_cnt;     // lines spent in the current v phase
    logic [9:0]  x;
    logic [9:0]  y;
    logic [9:0]  h_len;
    logic [9:0]  v_len;
    logic        h_last;
    logic        v_last;
    logic        line_end;
    logic        frame_end;

    function automatic scan_phase_e next_phase(scan_phase_e ph);
        case (ph)
            ph_active: return ph_front;
            ph_front:  return ph_pulse;
            ph_pulse:  return ph_back;
            default:   return ph_active;
        endcase
    endfunction

    // length of the phase we are in
    always_comb begin
        case (h_phase)
            ph_active: h_len = 10'(h_active);
            ph_front:  h_len = 10'(h_front);
            ph_pulse:  h_len = 10'(h_pulse);
            default:   h_len = 10'(h_back);
        endcase
        case (v_phase)
            ph_active: v_len = 10'(v_active);
            ph_front:  v_len = 10'(v_front);
            ph_pulse:  v_len = 10'(v_pulse);
            default:   v_len = 10'(v_back);
        endcase
    end

    assign h_last    = (h_cnt == h_len - 10'd1);
    assign v_last    = (v_cnt == v_len - 10'd1);
    assign line_end  = h_last && (h_phase == ph_back);
    assign frame_end = line_end && v_last && (v_phase == ph_back);

    // horizontal machine, one step per clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_phase <= ph_active;
            h_cnt   <= '0;
            x       <= '0;
        end else begin
            if (h_last) begin
                h_phase <= next_phase(h_phase);
                h_cnt   <= '0;
            end else begin
                h_cnt <= h_cnt + 10'd1;
            end
            x <= line_end ? 10'd0 : x + 10'd1;
        end
    end

    // vertical machine only moves at the last clock of a line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v_phase <= ph_active;
            v_cnt   <= '0;
            y       <= '0;
        end else if (line_end) begin
            if (v_last) begin
                v_phase <= next_phase(v_phase);
                v_cnt   <= '0;
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
            y <= frame_end ? 10'd0 : y + 10'd1;
        end
    end

    always_comb begin
        beam.x           = x;
        beam.y           = y;
        beam.active      = (h_phase == ph_active) && (v_phase == ph_active);
        beam.hsync_n     = (h_phase != ph_pulse);   // sync is active low
        beam.vsync_n     = (v_phase != ph_pulse);
        beam.frame_start = (x == 10'd0) && (y == 10'd0);
    end

    assign vblank = (y >= 10'(v_active));

endmodule

// File: rtl/vga_regs.sv
module vga_regs import vga_pkg::*; #(
    parameter int h_active = 640,
    parameter int v_active = 480
) (
    input  logic          clk,
    input  logic          rst,
    input  axil_req_t     axil_req,
    input  logic          frame_start,
    input  logic          vblank,
    output axil_rsp_t     axil_rsp,
    output logic          enable,
    output pattern_mode_e mode,
    output pixel_t        color
);

    logic        aw_rdy;    // drives awready and wready together
    logic        ar_rdy;
    logic        b_valid;
    logic [1:0]  b_resp;
    logic        r_valid;
    logic [31:0] r_data;
    logic [1:0]  r_resp;
    logic [31:0] frames;
    logic        wr_fire;
    logic        wr_ctrl;
    logic        ena_rise;
    logic [1:0]  wr_resp;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;

    // master holds address and data while ready is up, so that cycle is the handshake
    assign wr_fire  = aw_rdy;
    assign wr_ctrl  = wr_fire && axil_req.wstrb[0] && (axil_req.awaddr == reg_ctrl);
    assign ena_rise = wr_ctrl && axil_req.wdata[0] && !enable;

    always_comb begin
        case (axil_req.awaddr)
            reg_ctrl, reg_color, reg_frames, reg_status: wr_resp = resp_okay;
            default: wr_resp = resp_slverr;
        endcase

        rd_resp = resp_okay;
        rd_data = '0;
        case (axil_req.araddr)
            reg_ctrl:   rd_data = {29'd0, mode, enable};
            reg_color:  rd_data = {24'd0, color};
            reg_frames: rd_data = frames;
            // geometry readback above the vblank flag
            reg_status: rd_data = {16'(h_active), 12'(v_active), 3'd0, vblank};
            default:    rd_resp = resp_slverr;
        endcase
    end

    // handshake state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aw_rdy  <= 1'b0;
            ar_rdy  <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            aw_rdy <= axil_req.awvalid && axil_req.wvalid && !b_valid && !aw_rdy;
            ar_rdy <= axil_req.arvalid && !r_valid && !ar_rdy;

            if (wr_fire) begin
                b_valid <= 1'b1;
            end else if (b_valid && axil_req.bready) begin
                b_valid <= 1'b0;
            end

            if (ar_rdy) begin
                r_valid <= 1'b1;
            end else if (r_valid && axil_req.rready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // response payload, captured at the handshake
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            b_resp <= wr_resp;
        end
        if (ar_rdy) begin
            r_data <= rd_data;
            r_resp <= rd_resp;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable <= 1'b0;
            mode   <= mode_solid;
            color  <= '0;
            frames <= '0;
        end else begin
            if (wr_ctrl) begin
                enable <= axil_req.wdata[0];
                mode   <= pattern_mode_e'(axil_req.wdata[2:1]);
            end
            if (wr_fire && axil_req.wstrb[0] && (axil_req.awaddr == reg_color)) begin
                color <= pixel_t'(axil_req.wdata[7:0]);
            end

            if (ena_rise) begin
                frames <= '0;   // restart count on enable
            end else if (frame_start && enable) begin
                frames <= frames + 32'd1;
            end
        end
    end

    always_comb begin
        axil_rsp.awready = aw_rdy;
        axil_rsp.wready  = aw_rdy;
        axil_rsp.bvalid  = b_valid;
        axil_rsp.bresp   = b_resp;
        axil_rsp.arready = ar_rdy;
        axil_rsp.rvalid  = r_valid;
        axil_rsp.rdata   = r_data;
        axil_rsp.rresp   = r_resp;
    end

endmodule

// File: rtl/pattern_gen.sv
module pattern_gen import vga_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  beam_t         beam,
    input  pattern_mode_e mode,
    input  pixel_t        color,
    output pixel_t        pixel,
    output beam_t         beam_d
);

    // beam as seen in the blanking region, syncs released
    localparam beam_t beam_idle = '{
        x:           10'd0,
        y:           10'd0,
        active:      1'b0,
        hsync_n:     1'b1,
        vsync_n:     1'b1,
        frame_start: 1'b0
    };

    logic   on_grid;
    pixel_t next_pixel;

    always_comb begin
        on_grid = (beam.x[2:0] == 3'd0) || (beam.y[2:0] == 3'd0);   // every 8th row or column

        case (mode)
            mode_solid: next_pixel = color;
            mode_bars:  next_pixel = pixel_t'({1'b0, beam.x[9:3]});
            mode_grid:  next_pixel = on_grid ? pixel_t'(8'hff) : color;
            default:    next_pixel = pixel_t'(beam.x[7:0] ^ beam.y[7:0]);
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel  <= '0;
            beam_d <= beam_idle;
        end else begin
            pixel  <= next_pixel;
            beam_d <= beam;     // keeps position in step with pixel
        end
    end

endmodule

// File: rtl/vga_output.sv
module vga_output import vga_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  pixel_t     pixel,
    input  beam_t      beam_d,
    input  logic       enable,
    output rgb_t       rgb,
    output logic       hsync_n,
    output logic       vsync_n,
    output logic       blank_n,
    output logic [9:0] x,
    output logic [9:0] y
);

    // widen by repeating the msbs into the low bits
    function automatic rgb_t expand(pixel_t p);
        rgb_t c;
        c.red   = {p.red, p.red, p.red[2:1]};
        c.green = {p.green, p.green, p.green[2:1]};
        c.blue  = {4{p.blue}};
        return c;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb     <= '0;
            hsync_n <= 1'b1;
            vsync_n <= 1'b1;
            blank_n <= 1'b0;
            x       <= '0;
            y       <= '0;
        end else begin
            rgb     <= (beam_d.active && enable) ? expand(pixel) : '0;
            blank_n <= beam_d.active;   // still marks the region when disabled
            hsync_n <= beam_d.hsync_n;
            vsync_n <= beam_d.vsync_n;
            x       <= beam_d.x;
            y       <= beam_d.y;
        end
    end

endmodule

// File: rtl/vga_top.sv
module vga_top import vga_pkg::*; #(
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_pulse  = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_pulse  = 2,
    parameter int v_back   = 33
) (
    input  logic       clk,
    input  logic       rst,
    input  axil_req_t  axil_req,
    output axil_rsp_t  axil_rsp,
    output rgb_t       rgb,
    output logic       hsync_n,
    output logic       vsync_n,
    output logic       blank_n,
    output logic [9:0] x,
    output logic [9:0] y
);

    beam_t         beam;
    beam_t         beam_d;
    logic          vblank;
    logic          enable;
    pattern_mode_e mode;
    pixel_t        color;
    pixel_t        pixel;

    vga_timing #(
        .h_active (h_active),
        .h_front  (h_front),
        .h_pulse  (h_pulse),
        .h_back   (h_back),
        .v_active (v_active),
        .v_front  (v_front),
        .v_pulse  (v_pulse),
        .v_back   (v_back)
    ) i_vga_timing (
        .clk    (clk),
        .rst    (rst),
        .beam   (beam),
        .vblank (vblank)
    );

    vga_regs #(
        .h_active (h_active),
        .v_active (v_active)
    ) i_vga_regs (
        .clk         (clk),
        .rst         (rst),
        .axil_req    (axil_req),
        .frame_start (beam.frame_start),
        .vblank      (vblank),
        .axil_rsp    (axil_rsp),
        .enable      (enable),
        .mode        (mode),
        .color       (color)
    );

    pattern_gen i_pattern_gen (
        .clk    (clk),
        .rst    (rst),
        .beam   (beam),
        .mode   (mode),
        .color  (color),
        .pixel  (pixel),
        .beam_d (beam_d)
    );

    vga_output i_vga_output (
        .clk     (clk),
        .rst     (rst),
        .pixel   (pixel),
        .beam_d  (beam_d),
        .enable  (enable),
        .rgb     (rgb),
        .hsync_n (hsync_n),
        .vsync_n (vsync_n),
        .blank_n (blank_n),
        .x       (x),
        .y       (y)
    );

endmodule

// File: bench/vga_clk_gen.sv
module vga_clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: bench/vga_chk.sv
module vga_chk import vga_pkg::*; #(
    parameter int h_pulse = 96
) (
    input logic      clk,
    input logic      rst,
    input axil_req_t axil_req,
    input axil_rsp_t axil_rsp,
    input logic      hsync_n,
    input logic      vsync_n,
    input logic      blank_n
);
    timeunit 1ns;
    timeprecision 1ps;

    hsync_width: assert property (@(posedge clk) disable iff (rst)
        $fell(hsync_n) |-> ##h_pulse $rose(hsync_n))
        else $error("hsync_n low time differs from h_pulse");

    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else $error("rvalid dropped before rready");

    // video never shown during a sync pulse
    blank_in_sync: assert property (@(posedge clk) disable iff (rst)
        !(blank_n && (!hsync_n || !vsync_n)))
        else $error("blank_n high while a sync is low");

endmodule

bind vga_top vga_chk #(.h_pulse(h_pulse)) i_vga_chk (
    .clk      (clk),
    .rst      (rst),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .hsync_n  (hsync_n),
    .vsync_n  (vsync_n),
    .blank_n  (blank_n)
);

// File: bench/vga_tb.sv
module vga_tb import vga_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int h_act = 16;
    localparam int h_fp  = 2;
    localparam int h_sp  = 3;
    localparam int h_bp  = 3;
    localparam int v_act = 12;
    localparam int v_fp  = 2;
    localparam int v_sp  = 2;
    localparam int v_bp  = 2;
    localparam int line_len  = h_act + h_fp + h_sp + h_bp;
    localparam int frame_len = line_len * (v_act + v_fp + v_sp + v_bp);
    localparam int max_wait  = 4 * frame_len;

    typedef struct packed {
        rgb_t rgb;
        logic hsync_n;
        logic vsync_n;
        logic blank_n;
    } pins_t;

    logic          clk;
    logic          rst;
    axil_req_t     axil_req;
    axil_rsp_t     axil_rsp;
    rgb_t          rgb;
    logic          hsync_n;
    logic          vsync_n;
    logic          blank_n;
    logic [9:0]    x;
    logic [9:0]    y;
    logic          m_en;        // register state as last written
    pattern_mode_e m_mode;
    pixel_t        m_color;
    logic          cmp_on;
    logic          failed;

    vga_clk_gen i_vga_clk_gen (.clk(clk), .rst(rst));

    vga_top #(
        .h_active (h_act), .h_front (h_fp), .h_pulse (h_sp), .h_back (h_bp),
        .v_active (v_act), .v_front (v_fp), .v_pulse (v_sp), .v_back (v_bp)
    ) i_vga_top (
        .clk (clk), .rst (rst), .axil_req (axil_req), .axil_rsp (axil_rsp),
        .rgb (rgb), .hsync_n (hsync_n), .vsync_n (vsync_n), .blank_n (blank_n),
        .x (x), .y (y)
    );

    // expected pins for a pin position
    function automatic pins_t ref_pins(logic [9:0] px, logic [9:0] py, logic en,
                                       pattern_mode_e md, pixel_t col);
        pins_t      p;
        pixel_t     pix;
        logic [8:0] r9;
        logic [8:0] g9;
        int         xi;
        int         yi;
        xi = int'(px);
        yi = int'(py);
        case (md)
            mode_solid: pix = col;
            mode_bars:  pix = pixel_t'(8'(xi / 8));
            mode_grid:  pix = (xi % 8 == 0 || yi % 8 == 0) ? pixel_t'(8'hff) : col;
            default:    pix = pixel_t'(px[7:0] ^ py[7:0]);
        endcase
        p.blank_n = (xi < h_act) && (yi < v_act);
        p.hsync_n = !(xi >= h_act + h_fp && xi < h_act + h_fp + h_sp);
        p.vsync_n = !(yi >= v_act + v_fp && yi < v_act + v_fp + v_sp);
        r9 = {pix.red, pix.red, pix.red};
        g9 = {pix.green, pix.green, pix.green};
        p.rgb.red   = r9[8:1];
        p.rgb.green = g9[8:1];
        p.rgb.blue  = {4{pix.blue}};
        if (!(p.blank_n && en)) begin
            p.rgb = '0;
        end
        return p;
    endfunction

    task automatic fail_now(string msg);
        failed = 1'b1;
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rgb(string name, rgb_t got, rgb_t exp);
        if (got !== exp) fail_now($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) fail_now($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_resp(string name, logic [1:0] got, logic [1:0] exp);
        if (got !== exp) fail_now($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) fail_now($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    function automatic logic flag(int which);
        case (which)
            0: return axil_rsp.awready;
            1: return axil_rsp.bvalid;
            2: return axil_rsp.arready;
            3: return axil_rsp.rvalid;
            4: return blank_n;
            5: return (x == 10'd0) && (y == 10'd0);    // frame origin at the pins
            6: return !hsync_n;
            7: return !vsync_n;
            8: return hsync_n;
            default: return vsync_n;
        endcase
    endfunction

    task automatic wait_for(int which, string what);
        for (int i = 0; i <= max_wait; i++) begin
            @(negedge clk);
            if (flag(which)) return;
        end
        fail_now($sformatf("timed out waiting for %s", what));
    endtask

    task automatic run_frame();
        wait_for(5, "frame origin");
        @(negedge clk);
        wait_for(5, "next frame origin");
    endtask

    // low time and period of one sync pulse, in clocks
    task automatic measure_sync(int v, output int low, output int period);
        int n;
        wait_for(8 + v, "sync high");
        wait_for(6 + v, "sync fall");
        for (n = 1; n < max_wait; n++) begin
            @(negedge clk);
            if (flag(8 + v)) break;
        end
        low = n;
        for (n = n + 1; n < max_wait; n++) begin
            @(negedge clk);
            if (flag(6 + v)) break;
        end
        if (n >= max_wait) fail_now("sync pulse never repeated");
        period = n;
    endtask

    task automatic write_reg(logic [3:0] addr, logic [31:0] data, logic [3:0] strb,
                             output logic [1:0] resp);
        logic save;
        @(posedge clk);
        save   = cmp_on;
        cmp_on = 1'b0;      // pins are in transition around a register change
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= strb;
        wait_for(0, "awready");
        check_bit("wready", axil_rsp.wready, 1'b1);
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        wait_for(1, "bvalid");
        resp = axil_rsp.bresp;
        repeat (int'($urandom % 4) + 1) @(posedge clk);
        axil_req.bready <= 1'b1;
        @(posedge clk);
        axil_req.bready <= 1'b0;
        if (strb[0] && addr == reg_ctrl) begin
            m_en   = data[0];
            m_mode = pattern_mode_e'(data[2:1]);
        end
        if (strb[0] && addr == reg_color) m_color = pixel_t'(data[7:0]);
        repeat (3) @(posedge clk);
        cmp_on = save;
    endtask

    task automatic read_reg(logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp, output logic vs_at, output logic bl_at);
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        wait_for(2, "arready");
        vs_at = vsync_n;    // pins just before the edge that captures rdata
        bl_at = blank_n;
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        wait_for(3, "rvalid");
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        repeat (int'($urandom % 4) + 1) @(posedge clk);
        axil_req.rready <= 1'b1;
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    // compare every clock while the model is in step with the pins
    always @(negedge clk) begin
        pins_t e;
        if (cmp_on && !rst) begin
            e = ref_pins(x, y, m_en, m_mode, m_color);
            check_rgb("rgb", rgb, e.rgb);
            check_bit("hsync_n", hsync_n, e.hsync_n);
            check_bit("vsync_n", vsync_n, e.vsync_n);
            check_bit("blank_n", blank_n, e.blank_n);
        end
    end

    initial begin
        logic [31:0]   d;
        logic [31:0]   d0;
        logic [1:0]    rs;
        logic          vs;
        logic          bl;
        int            lo;
        int            per;
        int            n;
        int            j;
        pattern_mode_e order [4];
        pattern_mode_e t;
        pixel_t        c;

        void'($urandom(32'h5931_bc6c));
        axil_req = '0;
        cmp_on   = 1'b0;
        failed   = 1'b0;
        m_en     = 1'b0;
        m_mode   = mode_solid;
        m_color  = '0;

        @(posedge clk);
        @(negedge clk);     // still in reset
        check_rgb("rgb", rgb, '0);
        check_bit("hsync_n", hsync_n, 1'b1);
        check_bit("vsync_n", vsync_n, 1'b1);
        check_bit("blank_n", blank_n, 1'b0);
        check_word("x", 32'(x), 32'd0);
        check_word("y", 32'(y), 32'd0);
        check_bit("awready", axil_rsp.awready, 1'b0);
        check_bit("wready", axil_rsp.wready, 1'b0);
        check_bit("bvalid", axil_rsp.bvalid, 1'b0);
        check_bit("arready", axil_rsp.arready, 1'b0);
        check_bit("rvalid", axil_rsp.rvalid, 1'b0);
        for (n = 0; rst; n++) begin
            @(posedge clk);
            if (n > 10) fail_now("reset never released");
        end
        repeat (3) @(posedge clk);
        cmp_on = 1'b1;
        run_frame();        // disabled, rgb stays black

        measure_sync(0, lo, per);
        check_word("hsync_n low clocks", 32'(lo), 32'(h_sp));
        check_word("line period", 32'(per), 32'(line_len));
        measure_sync(1, lo, per);
        check_word("vsync_n low clocks", 32'(lo), 32'(v_sp * line_len));
        check_word("frame period", 32'(per), 32'(frame_len));

        // register access, enable and mode start cleared
        read_reg(reg_ctrl, d, rs, vs, bl);
        check_resp("rresp ctrl", rs, resp_okay);
        check_word("ctrl after reset", d, 32'd0);
        c = pixel_t'(8'($urandom));
        write_reg(reg_color, {24'd0, c}, 4'b0001, rs);
        check_resp("bresp", rs, resp_okay);
        read_reg(reg_color, d, rs, vs, bl);
        check_resp("rresp color", rs, resp_okay);
        check_word("color", d, {24'd0, c});
        write_reg(reg_color, 32'hffff_ffff, 4'b1110, rs);
        read_reg(reg_color, d, rs, vs, bl);
        check_word("color masked", d, {24'd0, m_color});
        write_reg(reg_ctrl, {29'd0, mode_grid, 1'b0}, 4'b0001, rs);
        write_reg(reg_ctrl, 32'd7, 4'b0000, rs);
        read_reg(reg_ctrl, d, rs, vs, bl);
        check_word("ctrl", d, {29'd0, mode_grid, 1'b0});
        read_reg(reg_frames, d0, rs, vs, bl);
        write_reg(reg_frames, $urandom, 4'b1111, rs);
        check_resp("bresp frames", rs, resp_okay);
        read_reg(reg_frames, d, rs, vs, bl);
        check_word("frames", d, d0);
        read_reg(4'h2, d, rs, vs, bl);
        check_resp("rresp unmapped", rs, resp_slverr);
        check_word("rdata unmapped", d, 32'd0);
        write_reg(4'h6, 32'd1, 4'b1111, rs);
        check_resp("bresp unmapped", rs, resp_slverr);

        // every mode for one frame, in shuffled order
        for (int i = 0; i < 4; i++) order[i] = pattern_mode_e'(2'(i));
        for (int i = 3; i > 0; i--) begin
            j = int'($urandom % (i + 1));
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int k = 0; k < 4; k++) begin
            c = pixel_t'(8'($urandom));
            write_reg(reg_color, {24'd0, c}, 4'b0001, rs);
            write_reg(reg_ctrl, {29'd0, order[k], 1'b1}, 4'b0001, rs);
            run_frame();
        end

        // frame counter, enable written inside the vsync pulse
        write_reg(reg_ctrl, 32'd0, 4'b0001, rs);
        wait_for(9, "vsync high");
        wait_for(7, "vsync fall");
        write_reg(reg_ctrl, {29'd0, mode_solid, 1'b1}, 4'b0001, rs);
        n = 1 + int'($urandom % 2);
        repeat (n) begin
            wait_for(9, "vsync high");
            wait_for(7, "vsync fall");
        end
        read_reg(reg_frames, d, rs, vs, bl);
        // read lands in the pulse, ahead of the next frame start
        if (vs !== 1'b0) fail_now("frame count read was not issued during the vsync pulse");
        check_word("frames", d, 32'(n));

        // vblank status
        wait_for(9, "vsync high");
        wait_for(7, "vsync fall");
        read_reg(reg_status, d, rs, vs, bl);
        if (vs !== 1'b0) fail_now("status read was not issued during the vsync pulse");
        check_bit("status vblank", d[0], 1'b1);
        wait_for(4, "active video");
        read_reg(reg_status, d, rs, vs, bl);
        if (bl !== 1'b1) fail_now("status read was not issued during active video");
        check_bit("status vblank", d[0], 1'b0);

        repeat (2) @(posedge clk);
        if (!failed) $display("Finished with no errors");
        else $display("Finished with errors");
        $finish;
    end

endmodule

// File: tb.f
rtl/vga_pkg.sv
rtl/vga_timing.sv
rtl/vga_regs.sv
rtl/pattern_gen.sv
rtl/vga_output.sv
rtl/vga_top.sv
bench/vga_clk_gen.sv
bench/vga_chk.sv
bench/vga_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module vga_tb -f tb.f -o vga_sim

./obj_dir/vga_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log || ! grep -q "Finished with no errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
